// ==== Makefile ====
TOP := sram_wb_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Isrc --top-module sram_wb_top \
	  src/sram_pkg.sv src/wb_req_decode.sv src/sram_phase_sequencer.sv \
	  src/sram_read_assembler.sv src/sram_wb_top.sv

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  -f filelist.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Checks failed" sim.log; then \
	  echo "Simulation reported errors"; exit 1; \
	fi
	@grep -q "All checks passed" sim.log || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// ==== dv/sram_chip_model.sv ====
`default_nettype none

`include "sram_settings.svh"

module sram_chip_model (
  input  wire logic                    i_clk,
  input  wire logic [`SRAM_ADDR_W-1:0] i_addr,
  inout  wire [`SRAM_DQ_W-1:0]         io_dq,
  input  wire logic                    i_ce_n,
  input  wire logic                    i_oe_n,
  input  wire logic                    i_we_n,
  input  wire logic                    i_lb_n,
  input  wire logic                    i_ub_n
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [`SRAM_DQ_W-1:0] mem [0:(1 << `SRAM_ADDR_W)-1];
  logic                  read_en;

  // Chip drives the bus while selected, output enabled and not writing
  assign read_en = !i_ce_n && !i_oe_n && i_we_n;

  // Each byte lane has its own enable
  assign io_dq[`SRAM_DQ_W-1:8] = (read_en && !i_ub_n) ? mem[i_addr][`SRAM_DQ_W-1:8] : 8'bz;
  assign io_dq[7:0]            = (read_en && !i_lb_n) ? mem[i_addr][7:0] : 8'bz;

  // Write lands mid-cycle, once address and data have settled
  always @(negedge i_clk) begin
    if (!i_ce_n && !i_we_n) begin
      if (!i_lb_n) begin
        mem[i_addr][7:0] <= io_dq[7:0];
      end
      if (!i_ub_n) begin
        mem[i_addr][`SRAM_DQ_W-1:8] <= io_dq[`SRAM_DQ_W-1:8];
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/sram_wb_sva.sv ====
`default_nettype none

module sram_wb_sva
  import sram_pkg::*;
(
  input  wire logic i_clk,
  input  wire logic i_reset,
  input  wire logic i_wb_ack,
  input  wire logic i_sram_ce_n,
  input  wire logic i_sram_we_n,
  input  wire logic i_start,
  input  sram_req_t i_req
);

  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // Ack is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge i_clk) disable iff (!i_reset)
    i_wb_ack |=> !i_wb_ack)
  else begin
    fail_count++;
    $error("Acknowledge stayed high for more than one cycle");
  end

  // Two write cycles with the chip selected, then back to idle
  write_enable_window: assert property (@(posedge i_clk) disable iff (!i_reset)
    i_start && i_req.we |=>
      !i_sram_we_n && !i_sram_ce_n ##1 !i_sram_we_n && !i_sram_ce_n ##1
      i_sram_we_n && i_sram_ce_n)
  else begin
    fail_count++;
    $error("Write enable not low with chip enable for exactly the two write cycles");
  end

  // Start is seen one edge after acceptance, so ack lands two edges later
  write_ack_timing: assert property (@(posedge i_clk) disable iff (!i_reset)
    i_start && i_req.we |-> !i_wb_ack ##1 !i_wb_ack ##1 !i_wb_ack ##1 i_wb_ack)
  else begin
    fail_count++;
    $error("Write acknowledge not on the third edge after acceptance");
  end

  read_ack_timing: assert property (@(posedge i_clk) disable iff (!i_reset)
    i_start && !i_req.we |->
      !i_wb_ack ##1 !i_wb_ack ##1 !i_wb_ack ##1 !i_wb_ack ##1 !i_wb_ack ##1 i_wb_ack)
  else begin
    fail_count++;
    $error("Read acknowledge not on the fifth edge after acceptance");
  end

  quiet_after_reset: assert property (@(posedge i_clk)
    !i_reset |=> !i_wb_ack && !i_start && i_sram_ce_n && i_sram_we_n)
  else begin
    fail_count++;
    $error("Outputs active in the cycle after reset");
  end

endmodule

bind sram_wb_top sram_wb_sva u_sva (
  .i_clk       (i_clk),
  .i_reset     (i_reset),
  .i_wb_ack    (o_wb_ack),
  .i_sram_ce_n (o_sram_ce_n),
  .i_sram_we_n (o_sram_we_n),
  .i_start     (start),
  .i_req       (req)
);

`default_nettype wire

// ==== dv/sram_wb_tb.sv ====
`default_nettype none

`include "sram_settings.svh"

module sram_wb_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_WORDS   = 24;
  localparam int ACK_TIMEOUT = 20;

  logic                    clk;
  logic                    reset;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [`WB_ADDR_W-1:0]   wb_adr;
  logic [`WB_SEL_W-1:0]    wb_sel;
  logic [`WB_DATA_W-1:0]   wb_dat_w;
  logic [`WB_DATA_W-1:0]   wb_dat_r;
  logic                    wb_ack;
  logic [`SRAM_ADDR_W-1:0] sram_addr;
  wire  [`SRAM_DQ_W-1:0]   sram_dq;
  logic                    sram_ce_n;
  logic                    sram_we_n;
  logic                    sram_lb_n;
  logic                    sram_ub_n;

  integer seed;
  int     errors   = 0;
  int     timeouts = 0;
  int     accesses = 0;
  int     acks     = 0;

  // Expected word contents, keyed by word address
  logic [`WB_DATA_W-1:0] shadow [logic [`WB_ADDR_W-1:0]];
  logic [`WB_ADDR_W-1:0] addrs [$];

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Keeps unselected byte lanes defined
  assign (weak0, weak1) sram_dq = '0;

  sram_wb_top u_dut (
    .i_clk       (clk),
    .i_reset     (reset),
    .i_wb_cyc    (wb_cyc),
    .i_wb_stb    (wb_stb),
    .i_wb_we     (wb_we),
    .i_wb_adr    (wb_adr),
    .i_wb_sel    (wb_sel),
    .i_wb_dat    (wb_dat_w),
    .o_wb_dat    (wb_dat_r),
    .o_wb_ack    (wb_ack),
    .o_sram_addr (sram_addr),
    .io_sram_dq  (sram_dq),
    .o_sram_ce_n (sram_ce_n),
    .o_sram_we_n (sram_we_n),
    .o_sram_lb_n (sram_lb_n),
    .o_sram_ub_n (sram_ub_n)
  );

  // Output enable tied low
  sram_chip_model u_sram (
    .i_clk  (clk),
    .i_addr (sram_addr),
    .io_dq  (sram_dq),
    .i_ce_n (sram_ce_n),
    .i_oe_n (1'b0),
    .i_we_n (sram_we_n),
    .i_lb_n (sram_lb_n),
    .i_ub_n (sram_ub_n)
  );

  always @(negedge clk) begin
    if (wb_ack) begin
      acks++;
    end
  end

  function automatic logic [`WB_DATA_W-1:0] byte_mask(input logic [`WB_SEL_W-1:0] sel);
    logic [`WB_DATA_W-1:0] mask;
    mask = '0;
    for (int b = 0; b < `WB_SEL_W; b++) begin
      if (sel[b]) begin
        mask[b*8 +: 8] = 8'hff;
      end
    end
    return mask;
  endfunction

  // Called 1 ns after a rising edge, returns at the same point of a later cycle
  task automatic run_cycle(input string name, input logic we,
                           input logic [`WB_ADDR_W-1:0] adr, input logic [`WB_SEL_W-1:0] sel,
                           input logic [`WB_DATA_W-1:0] dat, input bit hold,
                           output logic [`WB_DATA_W-1:0] rdata);
    bit got_ack;
    got_ack  = 1'b0;
    rdata    = '0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_sel   = sel;
    wb_dat_w = dat;
    for (int n = 0; n < ACK_TIMEOUT && !got_ack; n++) begin
      @(negedge clk);
      got_ack = wb_ack;
    end
    if (got_ack) begin
      rdata = wb_dat_r;
      accesses++;
    end else begin
      $display("Timeout in %s: no acknowledge within %0d cycles at address %h",
               name, ACK_TIMEOUT, adr);
      timeouts++;
    end
    // Master takes the ack on this edge
    @(posedge clk);
    #1;
    if (!hold || !got_ack) begin
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic write_word(input string name, input logic [`WB_ADDR_W-1:0] adr,
                            input logic [`WB_SEL_W-1:0] sel,
                            input logic [`WB_DATA_W-1:0] dat, input bit hold);
    logic [`WB_DATA_W-1:0] ignored;
    logic [`WB_DATA_W-1:0] mask;
    logic [`WB_DATA_W-1:0] stored;
    mask = byte_mask(sel);
    run_cycle(name, 1'b1, adr, sel, dat, hold, ignored);
    if (!shadow.exists(adr)) begin
      shadow[adr] = '0;
    end
    shadow[adr] = (shadow[adr] & ~mask) | (dat & mask);
    // Low half at the even chip address, high half at the odd one
    stored = {u_sram.mem[{adr, 1'b1}], u_sram.mem[{adr, 1'b0}]};
    assert (stored === shadow[adr]) else begin
      $display("Fail %s: address %h chip halves expected %h actual %h",
               name, adr, shadow[adr], stored);
      errors++;
    end
  endtask

  task automatic read_word(input string name, input logic [`WB_ADDR_W-1:0] adr,
                           input logic [`WB_SEL_W-1:0] sel, input bit hold);
    logic [`WB_DATA_W-1:0] expected;
    logic [`WB_DATA_W-1:0] actual;
    expected = shadow[adr] & byte_mask(sel);
    run_cycle(name, 1'b0, adr, sel, '0, hold, actual);
    assert (actual === expected) else begin
      $display("Fail %s: address %h sel %b expected %h actual %h",
               name, adr, sel, expected, actual);
      errors++;
    end
  endtask

  task automatic check_idle(input string name);
    assert (!wb_ack && sram_ce_n && sram_we_n) else begin
      $display("Fail %s: expected ack/ce_n/we_n 0/1/1 actual %b/%b/%b",
               name, wb_ack, sram_ce_n, sram_we_n);
      errors++;
    end
  endtask

  initial begin
    logic [`WB_ADDR_W-1:0] adr;
    logic [`WB_DATA_W-1:0] dat;
    logic [`WB_SEL_W-1:0]  sel;
    int                    sva_errors;
    seed     = 32'h4629;
    reset    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_sel   = '0;
    wb_dat_w = '0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b1;
    check_idle("after_reset");

    // First access after reset
    adr = `WB_ADDR_W'($random(seed));
    dat = `WB_DATA_W'($random(seed));
    write_word("first_write", adr, 4'hf, dat, 1'b0);
    read_word("first_read", adr, 4'hf, 1'b0);

    for (int i = 0; i < NUM_WORDS; i++) begin
      adr = `WB_ADDR_W'($random(seed));
      dat = `WB_DATA_W'($random(seed));
      addrs.push_back(adr);
      write_word("full_write", adr, 4'hf, dat, 1'b0);
    end
    foreach (addrs[i]) begin
      read_word("full_read", addrs[i], 4'hf, 1'b0);
    end

    foreach (addrs[i]) begin
      sel = `WB_SEL_W'($random(seed));
      dat = `WB_DATA_W'($random(seed));
      write_word("partial_write", addrs[i], sel, dat, 1'b0);
      read_word("partial_write_check", addrs[i], 4'hf, 1'b0);
    end

    foreach (addrs[i]) begin
      sel = `WB_SEL_W'($random(seed));
      read_word("partial_read", addrs[i], sel, 1'b0);
    end

    // Strobe stays high across each ack until the last read
    for (int i = 0; i < NUM_WORDS; i++) begin
      sel = `WB_SEL_W'($random(seed));
      dat = `WB_DATA_W'($random(seed));
      write_word("b2b_write", addrs[i], sel, dat, 1'b1);
      read_word("b2b_read", addrs[i], 4'hf, i != NUM_WORDS - 1);
    end
    check_idle("after_last_cycle");

    assert (acks == accesses) else begin
      $display("Acknowledge count %0d does not match %0d completed cycles", acks, accesses);
      errors++;
    end

    sva_errors = u_dut.u_sva.fail_count;
    $display("Closing report: %0d check errors, %0d timeouts, %0d assertion failures",
             errors, timeouts, sva_errors);
    if (errors + timeouts + sva_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+src
src/sram_pkg.sv
src/wb_req_decode.sv
src/sram_phase_sequencer.sv
src/sram_read_assembler.sv
src/sram_wb_top.sv
dv/sram_chip_model.sv
dv/sram_wb_sva.sv
dv/sram_wb_tb.sv

// ==== src/sram_phase_sequencer.sv ====
`default_nettype none

`include "sram_settings.svh"

module sram_phase_sequencer
  import sram_pkg::*;
(
  input  wire logic                 i_clk,
  input  wire logic                 i_reset,
  input  wire logic                 i_start,
  input  sram_req_t                 i_req,
  output sram_addr_t                o_sram_addr,
  inout  wire [`SRAM_DQ_W-1:0]      io_sram_dq,
  output logic                      o_sram_ce_n,
  output logic                      o_sram_we_n,
  output logic                      o_sram_lb_n,
  output logic                      o_sram_ub_n,
  output sram_beat_t                o_beat
);

  typedef enum logic [1:0] {
    st_idle,
    st_write,
    st_read
  } seq_state_e;

  // Phase numbers of the final cycle and of the first odd-address cycle
  localparam logic [`SRAM_PHASE_W-1:0] WR_LAST = `SRAM_PHASE_W'(`SRAM_WR_PHASES - 1);
  localparam logic [`SRAM_PHASE_W-1:0] RD_LAST = `SRAM_PHASE_W'(`SRAM_RD_PHASES - 1);
  localparam logic [`SRAM_PHASE_W-1:0] WR_HALF = `SRAM_PHASE_W'(`SRAM_WR_PHASES / 2);
  localparam logic [`SRAM_PHASE_W-1:0] RD_HALF = `SRAM_PHASE_W'(`SRAM_RD_PHASES / 2);

  seq_state_e               state_q;
  logic [`SRAM_PHASE_W-1:0] phase_q;

  logic                     last_phase;
  logic                     upper_half;
  logic                     drive_dq;
  logic [`SRAM_DQ_W-1:0]    wr_half;
  logic [1:0]               sel_half;

  // Where the current phase sits within its access
  always_comb begin
    last_phase = 1'b0;
    upper_half = 1'b0;
    case (state_q)
      st_write: begin
        last_phase = (phase_q == WR_LAST);
        upper_half = (phase_q >= WR_HALF);
      end
      st_read: begin
        last_phase = (phase_q == RD_LAST);
        upper_half = (phase_q >= RD_HALF);
      end
      default: begin
        last_phase = 1'b0;
        upper_half = 1'b0;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_reset) begin
      state_q <= st_idle;
      phase_q <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          phase_q <= '0;
          if (i_start) begin
            state_q <= i_req.we ? st_write : st_read;
          end
        end
        default: begin
          if (last_phase) begin
            state_q <= st_idle;
            phase_q <= '0;
          end else begin
            phase_q <= phase_q + 1'b1;
          end
        end
      endcase
    end
  end

  // Even halfword first, then odd
  assign o_sram_addr = {i_req.adr, upper_half};

  assign o_sram_ce_n = (state_q == st_idle);

  // Bus is ours only while writing
  assign drive_dq    = (state_q == st_write);
  assign o_sram_we_n = !drive_dq;

  assign wr_half = upper_half ? i_req.dat[`WB_DATA_W-1 -: `SRAM_DQ_W]
                              : i_req.dat[`SRAM_DQ_W-1:0];

  assign io_sram_dq = drive_dq ? wr_half : 'z;

  // Byte selects 1:0 for the even half, 3:2 for the odd half
  assign sel_half = upper_half ? i_req.sel[`WB_SEL_W-1 -: 2] : i_req.sel[1:0];

  always_comb begin
    if (state_q == st_idle) begin
      o_sram_ub_n = 1'b1;
      o_sram_lb_n = 1'b1;
    end else begin
      o_sram_ub_n = !sel_half[1];
      o_sram_lb_n = !sel_half[0];
    end
  end

  // Every read cycle samples the bus
  // later cycle of each address overwrites the earlier one downstream
  always_comb begin
    o_beat.valid = (state_q == st_read);
    o_beat.upper = upper_half;
    o_beat.last  = last_phase;
    o_beat.data  = io_sram_dq;
  end

endmodule

`default_nettype wire

// ==== src/sram_pkg.sv ====
`default_nettype none

`include "sram_settings.svh"

package sram_pkg;

  // Chip halfword address, word address plus the half select bit
  typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;

  // One accepted Wishbone request, held until its acknowledge
  typedef struct packed {
    logic                  we;
    logic [`WB_ADDR_W-1:0] adr;
    logic [`WB_DATA_W-1:0] dat;
    logic [`WB_SEL_W-1:0]  sel;
  } sram_req_t;

  // One halfword as seen on the chip data bus
  typedef struct packed {
    // Read data present in this cycle
    logic                  valid;
    // Odd chip address, bits 31:16 of the word
    logic                  upper;
    // Final phase of the access
    logic                  last;
    logic [`SRAM_DQ_W-1:0] data;
  } sram_beat_t;

endpackage

`default_nettype wire

// ==== src/sram_read_assembler.sv ====
`default_nettype none

`include "sram_settings.svh"

module sram_read_assembler
  import sram_pkg::*;
(
  input  wire logic                  i_clk,
  input  wire logic                  i_reset,
  input  sram_beat_t                 i_beat,
  input  sram_req_t                  i_req,
  output logic [`WB_DATA_W-1:0]      o_wb_dat,
  output logic                       o_wb_ack
);

  logic [`WB_DATA_W-1:0] byte_mask;

  // Unselected bytes read back as zero
  always_comb begin
    for (int i = 0; i < `WB_SEL_W; i++) begin
      byte_mask[i*8 +: 8] = {8{i_req.sel[i]}};
    end
  end

  // Read word, filled half by half
  always_ff @(posedge i_clk) begin
    if (i_beat.valid) begin
      if (i_beat.upper) begin
        o_wb_dat[`WB_DATA_W-1 -: `SRAM_DQ_W] <=
          i_beat.data & byte_mask[`WB_DATA_W-1 -: `SRAM_DQ_W];
      end else begin
        o_wb_dat[`SRAM_DQ_W-1:0] <= i_beat.data & byte_mask[`SRAM_DQ_W-1:0];
      end
    end
  end

  // One ack per access, reads and writes alike
  always_ff @(posedge i_clk) begin
    if (!i_reset) begin
      o_wb_ack <= 1'b0;
    end else begin
      o_wb_ack <= i_beat.last;
    end
  end

endmodule

`default_nettype wire

// ==== src/sram_settings.svh ====
`ifndef SRAM_SETTINGS_SVH
`define SRAM_SETTINGS_SVH

// Chip side, 256K x 16 asynchronous SRAM
`define SRAM_ADDR_W 18
`define SRAM_DQ_W 16

// Wishbone side, 32-bit words
`define WB_DATA_W 32
`define WB_ADDR_W 17
`define WB_SEL_W 4

// Halfword phases per access
// Write drives each half once, read holds each address for two cycles
`define SRAM_WR_PHASES 2
`define SRAM_RD_PHASES 4

// Wide enough to count the longest access
`define SRAM_PHASE_W 2

`endif

// ==== src/sram_wb_top.sv ====
`default_nettype none

`include "sram_settings.svh"

module sram_wb_top
  import sram_pkg::*;
(
  input  wire logic                   i_clk,
  input  wire logic                   i_reset,

  // Wishbone classic slave
  input  wire logic                   i_wb_cyc,
  input  wire logic                   i_wb_stb,
  input  wire logic                   i_wb_we,
  input  wire logic [`WB_ADDR_W-1:0]  i_wb_adr,
  input  wire logic [`WB_SEL_W-1:0]   i_wb_sel,
  input  wire logic [`WB_DATA_W-1:0]  i_wb_dat,
  output logic [`WB_DATA_W-1:0]       o_wb_dat,
  output logic                        o_wb_ack,

  // SRAM chip pins
  output logic [`SRAM_ADDR_W-1:0]     o_sram_addr,
  inout  wire [`SRAM_DQ_W-1:0]        io_sram_dq,
  output logic                        o_sram_ce_n,
  output logic                        o_sram_we_n,
  output logic                        o_sram_lb_n,
  output logic                        o_sram_ub_n
);

  logic       start;
  sram_req_t  req;
  sram_beat_t beat;

  wb_req_decode u_decode (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_wb_cyc (i_wb_cyc),
    .i_wb_stb (i_wb_stb),
    .i_wb_we  (i_wb_we),
    .i_wb_adr (i_wb_adr),
    .i_wb_sel (i_wb_sel),
    .i_wb_dat (i_wb_dat),
    .i_ack    (o_wb_ack),
    .o_start  (start),
    .o_req    (req)
  );

  sram_phase_sequencer u_sequencer (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_start     (start),
    .i_req       (req),
    .o_sram_addr (o_sram_addr),
    .io_sram_dq  (io_sram_dq),
    .o_sram_ce_n (o_sram_ce_n),
    .o_sram_we_n (o_sram_we_n),
    .o_sram_lb_n (o_sram_lb_n),
    .o_sram_ub_n (o_sram_ub_n),
    .o_beat      (beat)
  );

  sram_read_assembler u_assembler (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_beat   (beat),
    .i_req    (req),
    .o_wb_dat (o_wb_dat),
    .o_wb_ack (o_wb_ack)
  );

endmodule

`default_nettype wire

// ==== src/wb_req_decode.sv ====
`default_nettype none

`include "sram_settings.svh"

module wb_req_decode
  import sram_pkg::*;
(
  input  wire logic                  i_clk,
  input  wire logic                  i_reset,
  input  wire logic                  i_wb_cyc,
  input  wire logic                  i_wb_stb,
  input  wire logic                  i_wb_we,
  input  wire logic [`WB_ADDR_W-1:0] i_wb_adr,
  input  wire logic [`WB_SEL_W-1:0]  i_wb_sel,
  input  wire logic [`WB_DATA_W-1:0] i_wb_dat,
  input  wire logic                  i_ack,
  output logic                       o_start,
  output sram_req_t                  o_req
);

  logic busy_q;
  logic accept;

  // New cycle only while no access is in flight
  assign accept = i_wb_cyc && i_wb_stb && !busy_q;

  always_ff @(posedge i_clk) begin
    if (!i_reset) begin
      busy_q  <= 1'b0;
      o_start <= 1'b0;
    end else begin
      o_start <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (i_ack) begin
        // Busy is still set on the ack edge, so the old strobe is not taken again
        busy_q <= 1'b0;
      end
    end
  end

  // Request stays put until the next accepted cycle
  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_req.we  <= i_wb_we;
      o_req.adr <= i_wb_adr;
      o_req.dat <= i_wb_dat;
      o_req.sel <= i_wb_sel;
    end
  end

endmodule

`default_nettype wire
